//--- scalar_unit_cfg.svh
// Widths, depths and opcodes of the scalar unit; IMEM_DEPTH must be a power of two
`ifndef SCALAR_UNIT_CFG_SVH
`define SCALAR_UNIT_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Datapath sizes
//////////////////////////////////////////////////////////////////////
`define DATA_W		32		// Scalar word
`define REG_NUM		16		// Scalar registers, one bank
`define IMEM_DEPTH	64		// Instruction slots
`define IMM_W		16		// Immediate, sign extended to DATA_W

//////////////////////////////////////////////////////////////////////
// Opcodes, 3 bits each
//////////////////////////////////////////////////////////////////////
`define OP_NOP		3'd0	// Dropped at dispatch
`define OP_LDI		3'd1	// dst = sext(imm)
`define OP_ADD		3'd2
`define OP_SUB		3'd3	// src1 minus src2, wraps
`define OP_AND		3'd4
`define OP_OR		3'd5
`define OP_XOR		3'd6

`endif

//--- scalar_pkg.sv
// Types of the scalar pipeline; the instruction word has exactly 32 bits with no spare field
`include "scalar_unit_cfg.svh"

package scalar_pkg;

	typedef logic [`DATA_W-1:0]					data_t;
	typedef logic [$clog2(`REG_NUM)-1:0]		reg_idx_t;
	typedef logic [$clog2(`IMEM_DEPTH):0]		pc_t;		// One extra bit to count a full program
	typedef logic [2:0]							opcode_t;
	typedef logic [`IMM_W-1:0]					imm_t;

	// Instruction word as stored
	typedef struct packed {
		logic		vec;		// Unit select, set for the vector unit
		opcode_t	op;
		reg_idx_t	dst;
		reg_idx_t	src1;
		reg_idx_t	src2;
		imm_t		imm;
	} instr_t;

	// Scalar operation leaving dispatch
	typedef struct packed {
		logic		valid;
		opcode_t	op;
		reg_idx_t	dst;
		reg_idx_t	src1;
		reg_idx_t	src2;
		imm_t		imm;
	} scalar_op_t;

	// Operand register, both sources resolved
	typedef struct packed {
		logic		valid;
		opcode_t	op;
		reg_idx_t	dst;
		data_t		a;
		data_t		b;
	} operand_t;

	typedef struct packed {
		logic		valid;
		reg_idx_t	dst;
		data_t		data;
	} wb_t;

	// Command to the vector unit
	typedef struct packed {
		logic		valid;
		instr_t		instr;
	} vcmd_t;

	typedef struct packed {
		logic		busy;
		logic		done;
		logic		zero;
		logic		neg;
	} status_t;

endpackage

//--- instr_mem.sv
// Instruction store; writes only while run_en is low, program cleared by reset alone
`timescale 1ns/1ps
`include "scalar_unit_cfg.svh"

module instr_mem (
	input	logic					clock,
	input	logic					reset,
	input	logic					run_en,
	input	logic					st_req,
	input	scalar_pkg::instr_t		st_instr,
	output	logic					st_ack,
	input	logic					rd_en,
	input	scalar_pkg::pc_t		rd_addr,
	output	scalar_pkg::instr_t		rd_instr,
	output	scalar_pkg::pc_t		prog_len
);
	import scalar_pkg::*;

	localparam int addr_w = $clog2(`IMEM_DEPTH);

	instr_t		mem [`IMEM_DEPTH];
	pc_t		wr_ptr;
	logic		full;
	logic		accept;

	assign full		= (wr_ptr == pc_t'(`IMEM_DEPTH));
	assign accept	= st_req && !run_en && !full;	// Refused requests are simply ignored
	assign prog_len	= wr_ptr;

	// Write pointer and acknowledge
	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr	<= '0;
			st_ack	<= 1'b0;
		end else begin
			st_ack	<= accept;
			if (accept)
				wr_ptr	<= wr_ptr + 1'b1;
		end
	end

	// Storage and registered read port
	always_ff @(posedge clock) begin
		if (accept)
			mem[wr_ptr[addr_w-1:0]]	<= st_instr;
		if (rd_en)
			rd_instr	<= mem[rd_addr[addr_w-1:0]];
	end

endmodule

//--- fetch_stage.sv
// In-order fetch; pauses while run_en is low, stops at the program length, no branches
`timescale 1ns/1ps

module fetch_stage (
	input	logic					clock,
	input	logic					reset,
	input	logic					run_en,
	input	scalar_pkg::pc_t		prog_len,
	input	scalar_pkg::instr_t		mem_instr,
	output	logic					rd_en,
	output	scalar_pkg::pc_t		pc,
	output	logic					fetch_valid,
	output	scalar_pkg::instr_t		fetch_instr
);

	logic	at_end;

	//////////////////////////////////////////////////////////////////////
	// Read issue
	//////////////////////////////////////////////////////////////////////

	// End of program once pc has caught up with the stored length
	assign at_end	= (pc >= prog_len);
	assign rd_en	= run_en && !at_end;

	always_ff @(posedge clock) begin
		if (reset) begin
			pc	<= '0;
		end else if (rd_en) begin
			pc	<= pc + 1'b1;		// One instruction per enabled cycle
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Returned instruction
	//////////////////////////////////////////////////////////////////////

	// Memory read takes one cycle, so the strobe follows rd_en by one
	always_ff @(posedge clock) begin
		if (reset) begin
			fetch_valid	<= 1'b0;
		end else begin
			fetch_valid	<= rd_en;
		end
	end

	assign fetch_instr	= mem_instr;	// Only meaningful with fetch_valid

endmodule

//--- dispatch_stage.sv
// Routes each fetched instruction to the vector unit or the scalar path; NOPs are dropped
`timescale 1ns/1ps
`include "scalar_unit_cfg.svh"

module dispatch_stage (
	input	logic					clock,
	input	logic					reset,
	input	logic					fetch_valid,
	input	scalar_pkg::instr_t		fetch_instr,
	output	scalar_pkg::vcmd_t		v_command,
	output	scalar_pkg::scalar_op_t	s_op
);

	logic	to_vec;
	logic	to_scalar;

	assign to_vec		= fetch_valid && fetch_instr.vec;
	assign to_scalar	= fetch_valid && !fetch_instr.vec && (fetch_instr.op != `OP_NOP);

	// Valid bits, exactly one side per slot at most
	always_ff @(posedge clock) begin
		if (reset) begin
			v_command.valid	<= 1'b0;
			s_op.valid		<= 1'b0;
		end else begin
			v_command.valid	<= to_vec;
			s_op.valid		<= to_scalar;
		end
	end

	// Payload follows every fetched slot
	always_ff @(posedge clock) begin
		if (fetch_valid) begin
			v_command.instr	<= fetch_instr;		// Passed unchanged
			s_op.op			<= fetch_instr.op;
			s_op.dst		<= fetch_instr.dst;
			s_op.src1		<= fetch_instr.src1;
			s_op.src2		<= fetch_instr.src2;
			s_op.imm		<= fetch_instr.imm;
		end
	end

endmodule

//--- operand_stage.sv
// Register read with bypass from execute and write-back; one bank, two read ports
`timescale 1ns/1ps
`include "scalar_unit_cfg.svh"

module operand_stage (
	input	logic					clock,
	input	logic					reset,
	input	scalar_pkg::scalar_op_t	s_op,
	input	scalar_pkg::wb_t		alu_fwd,
	input	scalar_pkg::wb_t		wb,
	output	scalar_pkg::operand_t	operand
);
	import scalar_pkg::*;

	data_t		rf [`REG_NUM];
	data_t		src1_val;
	data_t		src2_val;
	data_t		imm_ext;
	logic		is_ldi;

	// Newest value of a register: ALU result first, then write-back, then the file
	function automatic data_t pick(input reg_idx_t idx, input wb_t fwd, input wb_t late,
			input data_t rf_val);
		data_t	val;
		if (fwd.valid && fwd.dst == idx)
			val	= fwd.data;
		else if (late.valid && late.dst == idx)
			val	= late.data;
		else
			val	= rf_val;
		return val;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Register file
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `REG_NUM; i++)
				rf[i]	<= '0;
		end else if (wb.valid) begin
			rf[wb.dst]	<= wb.data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Bypass network
	//////////////////////////////////////////////////////////////////////
	assign is_ldi	= (s_op.op == `OP_LDI);
	assign imm_ext	= {{(`DATA_W-`IMM_W){s_op.imm[`IMM_W-1]}}, s_op.imm};

	always_comb begin
		src1_val	= pick(s_op.src1, alu_fwd, wb, rf[s_op.src1]);
		src2_val	= pick(s_op.src2, alu_fwd, wb, rf[s_op.src2]);
	end

	// Operand pipeline register
	always_ff @(posedge clock) begin
		if (reset)
			operand.valid	<= 1'b0;
		else
			operand.valid	<= s_op.valid;
	end

	always_ff @(posedge clock) begin
		operand.op	<= s_op.op;
		operand.dst	<= s_op.dst;
		operand.a	<= is_ldi ? '0 : src1_val;		// LDI reads no register
		operand.b	<= is_ldi ? imm_ext : src2_val;
	end

endmodule

//--- exec_stage.sv
// Single-cycle ALU; result forwarded combinationally and registered as the write-back
`timescale 1ns/1ps
`include "scalar_unit_cfg.svh"

module exec_stage (
	input	logic					clock,
	input	logic					reset,
	input	scalar_pkg::operand_t	operand,
	output	scalar_pkg::wb_t		alu_fwd,
	output	scalar_pkg::wb_t		wb,
	output	logic					zero,
	output	logic					neg
);
	import scalar_pkg::*;

	data_t	result;

	//////////////////////////////////////////////////////////////////////
	// ALU
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		case (operand.op)
			`OP_LDI:	result = operand.b;
			`OP_ADD:	result = operand.a + operand.b;
			`OP_SUB:	result = operand.a - operand.b;		// Modulo 2^DATA_W
			`OP_AND:	result = operand.a & operand.b;
			`OP_OR:		result = operand.a | operand.b;
			`OP_XOR:	result = operand.a ^ operand.b;
			default:	result = '0;
		endcase
	end

	// Bypass source for the operand stage
	assign alu_fwd.valid	= operand.valid;
	assign alu_fwd.dst		= operand.dst;
	assign alu_fwd.data		= result;

	//////////////////////////////////////////////////////////////////////
	// Write-back register and flags
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			wb.valid	<= 1'b0;
			zero		<= 1'b0;
			neg			<= 1'b0;
		end else begin
			wb.valid	<= operand.valid;
			if (operand.valid) begin
				zero	<= (result == '0);
				neg		<= result[`DATA_W-1];	// Sign of the last result
			end
		end
	end

	always_ff @(posedge clock) begin
		wb.dst	<= operand.dst;
		wb.data	<= result;
	end

endmodule

//--- scalar_unit.sv
// Scalar unit top; no back-pressure, every output strobe must be taken when it appears
`timescale 1ns/1ps

module scalar_unit (
	input	logic					clock,
	input	logic					reset,
	input	logic					run_en,
	input	logic					st_req,
	input	scalar_pkg::instr_t		st_instr,
	output	logic					st_ack,
	output	scalar_pkg::vcmd_t		v_command,
	output	scalar_pkg::wb_t		scalar_data,
	output	scalar_pkg::status_t	status
);
	import scalar_pkg::*;

	logic		rd_en;
	pc_t		pc;
	pc_t		prog_len;
	instr_t		mem_instr;
	logic		fetch_valid;
	instr_t		fetch_instr;
	scalar_op_t	s_op;
	operand_t	operand;
	wb_t		alu_fwd;
	wb_t		wb;
	logic		zero;
	logic		neg;

	//////////////////////////////////////////////////////////////////////
	// Front end
	//////////////////////////////////////////////////////////////////////
	instr_mem i_instr_mem (
		.clock(clock), .reset(reset), .run_en(run_en),
		.st_req(st_req), .st_instr(st_instr), .st_ack(st_ack),
		.rd_en(rd_en), .rd_addr(pc), .rd_instr(mem_instr), .prog_len(prog_len)
	);

	fetch_stage i_fetch_stage (
		.clock(clock), .reset(reset), .run_en(run_en), .prog_len(prog_len),
		.mem_instr(mem_instr), .rd_en(rd_en), .pc(pc),
		.fetch_valid(fetch_valid), .fetch_instr(fetch_instr)
	);

	dispatch_stage i_dispatch_stage (
		.clock(clock), .reset(reset), .fetch_valid(fetch_valid),
		.fetch_instr(fetch_instr), .v_command(v_command), .s_op(s_op)
	);

	//////////////////////////////////////////////////////////////////////
	// Scalar back end
	//////////////////////////////////////////////////////////////////////
	operand_stage i_operand_stage (
		.clock(clock), .reset(reset), .s_op(s_op),
		.alu_fwd(alu_fwd), .wb(wb), .operand(operand)
	);

	exec_stage i_exec_stage (
		.clock(clock), .reset(reset), .operand(operand),
		.alu_fwd(alu_fwd), .wb(wb), .zero(zero), .neg(neg)
	);

	assign scalar_data	= wb;

	// Status from the stage valids
	assign status.busy	= rd_en || fetch_valid || v_command.valid || s_op.valid
						|| operand.valid || wb.valid;
	assign status.done	= (prog_len != '0) && (pc == prog_len) && !status.busy;
	assign status.zero	= zero;
	assign status.neg	= neg;

endmodule

//--- tb_scalar_unit.sv
// Directed testbench for scalar_unit; reset between tests is the only way to clear the program
`timescale 1ns/1ps
`include "scalar_unit_cfg.svh"

module tb_scalar_unit;
	import scalar_pkg::*;

	localparam int total_len	= 82;					// Program lengths summed over all tests
	localparam int num_tests	= 6;
	localparam int cycle_limit	= 2 * total_len + 40 * num_tests;

	logic		clock;
	logic		reset;
	logic		run_en;
	logic		st_req;
	instr_t		st_instr;
	logic		st_ack;
	vcmd_t		v_command;
	wb_t		scalar_data;
	status_t	status;

	data_t		model_rf [`REG_NUM];
	wb_t		exp_wb [$];
	vcmd_t		exp_v [$];
	status_t	exp_status;
	logic		exp_ack;
	int			stored;
	int			error_count = 0;
	int			test_count = 0;
	int			failed_count = 0;
	int			cycles = 0;
	logic [15:0]	lfsr_state = 16'd58;

	scalar_unit i_dut (
		.clock(clock), .reset(reset), .run_en(run_en), .st_req(st_req),
		.st_instr(st_instr), .st_ack(st_ack), .v_command(v_command),
		.scalar_data(scalar_data), .status(status)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// Run limit
	always @(posedge clock) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("Timeout: run did not finish within %0d cycles", cycle_limit);
			$display("Simulation failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Compare tasks and random bits
	//////////////////////////////////////////////////////////////////////
	task automatic note_error(input string msg);
		$display("Error at %0t: %s", $time, msg);
		error_count++;
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		if (got !== want) begin
			$display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, want);
			error_count++;
		end
	endtask

	task automatic check_wb(input string name, input wb_t got, input wb_t want);
		if (got !== want) begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, want);
			error_count++;
		end
	endtask

	task automatic check_vcmd(input string name, input vcmd_t got, input vcmd_t want);
		if (got !== want) begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, want);
			error_count++;
		end
	endtask

	task automatic check_status(input string name, input status_t got, input status_t want);
		if (got !== want) begin
			$display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, want);
			error_count++;
		end
	endtask

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int k = 0; k < n; k++) begin
			val = {val[30:0], lfsr_state[15]};
			lfsr_state = lfsr_next(lfsr_state);		// One step per bit
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Output monitor sampled mid-cycle
	//////////////////////////////////////////////////////////////////////
	always @(negedge clock) begin
		if (reset) begin
			exp_ack = 1'b0;
			stored = 0;
		end else begin
			check_bit("st_ack", st_ack, exp_ack);
			exp_ack = st_req && !run_en && (stored < `IMEM_DEPTH);
			if (exp_ack)
				stored++;
			if (status.done && (exp_wb.size() != 0 || exp_v.size() != 0))
				note_error("status.done high while results are still expected");
			if (scalar_data.valid) begin
				if (exp_wb.size() == 0)
					note_error("write-back on scalar_data with none expected");
				else
					check_wb("scalar_data", scalar_data, exp_wb.pop_front());
			end
			if (v_command.valid) begin
				if (exp_v.size() == 0)
					note_error("vector command with none expected");
				else
					check_vcmd("v_command", v_command, exp_v.pop_front());
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Reference model and stimulus helpers
	//////////////////////////////////////////////////////////////////////
	task automatic model_instr(input instr_t ins);
		data_t	a;
		data_t	b;
		data_t	r;
		wb_t	w;
		vcmd_t	v;
		a = model_rf[ins.src1];
		b = model_rf[ins.src2];
		if (ins.vec) begin
			v.valid = 1'b1;
			v.instr = ins;
			exp_v.push_back(v);
		end else if (ins.op != `OP_NOP) begin
			case (ins.op)
				`OP_LDI:	r = data_t'($signed(ins.imm));
				`OP_ADD:	r = a + b;
				`OP_SUB:	r = a - b;
				`OP_AND:	r = a & b;
				`OP_OR:		r = a | b;
				`OP_XOR:	r = a ^ b;
				default:	r = '0;
			endcase
			model_rf[ins.dst] = r;
			w.valid = 1'b1;
			w.dst = ins.dst;
			w.data = r;
			exp_wb.push_back(w);
			exp_status.zero = (r == '0);
			exp_status.neg = r[`DATA_W-1];
		end
	endtask

	task automatic store_instr(input instr_t ins);
		@(posedge clock);
		st_req <= 1'b1;
		st_instr <= ins;
	endtask

	task automatic end_store();
		@(posedge clock);
		st_req <= 1'b0;
	endtask

	task automatic put(input logic vec, input opcode_t op, input reg_idx_t dst,
			input reg_idx_t s1, input reg_idx_t s2, input logic [15:0] imm);
		instr_t	ins;
		ins = {vec, op, dst, s1, s2, imm};
		store_instr(ins);
		model_instr(ins);
	endtask

	task automatic apply_reset();
		@(posedge clock);
		reset <= 1'b1;
		run_en <= 1'b0;
		st_req <= 1'b0;
		exp_wb.delete();
		exp_v.delete();
		exp_status = '0;
		for (int i = 0; i < `REG_NUM; i++)
			model_rf[i] = '0;
		repeat (10) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
	endtask

	// Enable fetch, wait for done, then check the final status
	task automatic run_to_done();
		status_t	want;
		@(posedge clock);
		run_en <= 1'b1;
		@(negedge clock);
		while (!status.done)
			@(negedge clock);
		want = exp_status;
		want.busy = 1'b0;
		want.done = 1'b1;
		check_status("status", status, want);
		if (exp_wb.size() != 0 || exp_v.size() != 0)
			note_error("expected results were never produced");
		@(posedge clock);
		run_en <= 1'b0;
	endtask

	task automatic report_test(input string name, input int errs_before);
		test_count++;
		if (error_count == errs_before) begin
			$display("Test %s: pass", name);
		end else begin
			failed_count++;
			$display("Test %s: fail with %0d errors", name, error_count - errs_before);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////
	task automatic test_reset_store();
		int	errs;
		errs = error_count;
		apply_reset();
		check_bit("st_ack", st_ack, 1'b0);
		check_bit("v_command.valid", v_command.valid, 1'b0);
		check_bit("scalar_data.valid", scalar_data.valid, 1'b0);
		check_status("status", status, '0);
		@(posedge clock);
		run_en <= 1'b1;
		store_instr({1'b0, `OP_LDI, 4'd7, 4'd0, 4'd0, 16'h0777});	// Refused without ack
		store_instr({1'b0, `OP_LDI, 4'd8, 4'd0, 4'd0, 16'h0888});
		end_store();
		@(posedge clock);
		run_en <= 1'b0;
		put(0, `OP_LDI, 1, 0, 0, 16'h0011);
		put(0, `OP_LDI, 2, 0, 0, 16'h8000);
		put(0, `OP_LDI, 3, 0, 0, 16'h0000);
		end_store();
		run_to_done();
		report_test("reset and store", errs);
	endtask

	task automatic test_alu();
		int	errs;
		errs = error_count;
		apply_reset();
		put(0, `OP_LDI, 1, 0, 0, 16'd5);
		put(0, `OP_LDI, 2, 0, 0, 16'd9);
		put(0, `OP_LDI, 3, 0, 0, 16'h7FFF);
		put(0, `OP_LDI, 4, 0, 0, 16'hFFFF);
		put(0, `OP_NOP, 0, 0, 0, 16'h0);
		put(0, `OP_NOP, 0, 0, 0, 16'h0);
		put(0, `OP_ADD, 5, 1, 2, 16'h0);
		put(0, `OP_SUB, 6, 1, 2, 16'h0);		// Wraps below zero
		put(0, `OP_AND, 7, 3, 4, 16'h0);
		put(0, `OP_OR, 8, 1, 3, 16'h0);
		put(0, `OP_XOR, 9, 4, 1, 16'h0);
		put(0, `OP_SUB, 10, 1, 1, 16'h0);		// Zero flag
		end_store();
		run_to_done();
		report_test("alu", errs);
	endtask

	// Producers at distance 1, 2 and 3
	task automatic test_bypass();
		int	errs;
		errs = error_count;
		apply_reset();
		put(0, `OP_LDI, 1, 0, 0, 16'd10);
		put(0, `OP_LDI, 5, 0, 0, 16'd1);
		put(0, `OP_LDI, 6, 0, 0, 16'd2);
		put(0, `OP_SUB, 7, 1, 5, 16'h0);
		put(0, `OP_ADD, 2, 7, 6, 16'h0);
		put(0, `OP_XOR, 3, 2, 7, 16'h0);
		put(0, `OP_OR, 4, 3, 2, 16'h0);
		put(0, `OP_ADD, 8, 4, 4, 16'h0);
		put(0, `OP_SUB, 9, 1, 8, 16'h0);		// Negative result
		end_store();
		run_to_done();
		report_test("bypass", errs);
	endtask

	task automatic test_vector();
		int	errs;
		errs = error_count;
		apply_reset();
		put(0, `OP_LDI, 1, 0, 0, 16'h1234);
		put(1, `OP_ADD, 1, 2, 3, 16'hBEEF);		// Must not touch r1
		put(0, `OP_NOP, 0, 0, 0, 16'h0);
		put(1, `OP_LDI, 2, 0, 0, 16'h5A5A);
		put(0, `OP_ADD, 2, 1, 1, 16'h0);
		put(1, `OP_NOP, 0, 0, 0, 16'h0);
		put(0, `OP_LDI, 3, 0, 0, 16'hFFFB);
		put(1, `OP_XOR, 3, 3, 1, 16'h00FF);
		end_store();
		run_to_done();
		report_test("vector dispatch", errs);
	endtask

	task automatic test_pause();
		int	errs;
		errs = error_count;
		apply_reset();
		put(0, `OP_LDI, 1, 0, 0, 16'd1);
		put(0, `OP_LDI, 2, 0, 0, 16'd2);
		put(0, `OP_ADD, 3, 1, 2, 16'h0);
		put(0, `OP_ADD, 4, 3, 3, 16'h0);
		put(0, `OP_SUB, 5, 4, 1, 16'h0);
		put(0, `OP_AND, 6, 5, 4, 16'h0);
		put(0, `OP_OR, 7, 6, 2, 16'h0);
		put(0, `OP_XOR, 8, 7, 3, 16'h0);
		put(0, `OP_ADD, 9, 8, 8, 16'h0);
		put(0, `OP_SUB, 10, 9, 9, 16'h0);
		end_store();
		@(posedge clock);
		run_en <= 1'b1;
		repeat (3) @(posedge clock);
		run_en <= 1'b0;
		repeat (4) begin
			@(negedge clock);
			if (status.done)
				note_error("status.done high during pause");
		end
		run_to_done();
		report_test("pause and resume", errs);
	endtask

	task automatic test_random();
		int				errs;
		logic [31:0]	bits;
		logic			vec;
		opcode_t		op;
		reg_idx_t		dst;
		reg_idx_t		s1;
		reg_idx_t		s2;
		errs = error_count;
		apply_reset();
		for (int n = 0; n < 40; n++) begin
			take_bits(3, bits);
			vec = (bits[2:0] == 3'd0);			// About one in eight to the vector unit
			take_bits(3, bits);
			op = (bits[2:0] == 3'd7) ? `OP_LDI : bits[2:0];
			take_bits(4, bits);
			dst = bits[3:0];
			take_bits(4, bits);
			s1 = bits[3:0];
			take_bits(4, bits);
			s2 = bits[3:0];
			take_bits(16, bits);
			put(vec, op, dst, s1, s2, bits[15:0]);
		end
		end_store();
		run_to_done();
		report_test("random program", errs);
	endtask

	initial begin
		reset = 1'b1;
		run_en = 1'b0;
		st_req = 1'b0;
		st_instr = '0;
		test_reset_store();
		test_alu();
		test_bypass();
		test_vector();
		test_pause();
		test_random();
		repeat (2) @(posedge clock);
		$display("Tests run %0d, failed %0d, errors %0d", test_count, failed_count, error_count);
		if (error_count == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- scalar_unit.f
+incdir+.
scalar_pkg.sv
instr_mem.sv
fetch_stage.sv
dispatch_stage.sv
operand_stage.sv
exec_stage.sv
scalar_unit.sv
tb_scalar_unit.sv

//--- run.sh
#!/bin/sh
# Builds and runs the scalar_unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_scalar_unit \
	-f scalar_unit.f -o sim_tb > build.log 2>&1 \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	|| { cat build.log; echo "Build or run error"; exit 1; }
cat sim.log
grep -q "Simulation completed successfully" sim.log \
	&& { echo "PASS"; exit 0; } \
	|| { echo "FAIL"; exit 1; }
